//--- verilog/vcr_pkg.sv
// vcr_pkg
// shared constants and types of the four-port virtual-channel router

package vcr_pkg;

  // ====================
  // router geometry
  // ====================
  localparam int NUM_PORTS     = 4;
  localparam int NUM_VC        = 2;
  localparam int VC_DEPTH      = 2;
  localparam int VC_ID_WIDTH   = 1;
  localparam int PAYLOAD_WIDTH = 16;

  // a counter holds 0 to VC_DEPTH
  localparam int CREDIT_WIDTH  = 2;
  localparam logic [CREDIT_WIDTH-1:0] CREDIT_FULL = CREDIT_WIDTH'(VC_DEPTH);

  // index into one VC buffer
  localparam int PTR_WIDTH     = $clog2(VC_DEPTH);

  // ====================
  // types
  // ====================
  // port directions, also used as port index
  typedef enum logic [1:0] {
    DIR_NORTH = 2'd0,
    DIR_EAST  = 2'd1,
    DIR_SOUTH = 2'd2,
    DIR_WEST  = 2'd3
  } dir_e;

  // single-flit packet, header carries the output port
  typedef struct packed {
    dir_e                     dst;
    logic [PAYLOAD_WIDTH-1:0] payload;
  } flit_t;

endpackage

//--- verilog/vc_input_port.sv
// vc_input_port
// per-VC circular flit buffers for one router input
// separate read pointers for allocation and for switch traversal
// a credit goes back upstream when a flit leaves the buffer

module vc_input_port (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 data_v_i,
  input  logic [vcr_pkg::VC_ID_WIDTH-1:0]      data_vc_i,
  input  vcr_pkg::flit_t                       data_i,
  output logic                                 credit_v_o,
  output logic [vcr_pkg::VC_ID_WIDTH-1:0]      credit_vc_o,
  output logic [vcr_pkg::NUM_VC-1:0]           head_v_o,
  output vcr_pkg::dir_e [vcr_pkg::NUM_VC-1:0]  head_dst_o,
  input  logic                                 alloc_pop_i,
  input  logic [vcr_pkg::NUM_VC-1:0]           alloc_vc_oh_i,
  input  logic                                 st_pop_i,
  input  logic [vcr_pkg::NUM_VC-1:0]           st_vc_oh_i,
  output vcr_pkg::flit_t                       st_flit_o
);

  // flit at the traversal pointer of each VC
  vcr_pkg::flit_t [vcr_pkg::NUM_VC-1:0] st_head;

  function automatic logic [vcr_pkg::PTR_WIDTH-1:0] next_ptr(
    input logic [vcr_pkg::PTR_WIDTH-1:0] ptr
  );
    if (int'(ptr) == vcr_pkg::VC_DEPTH - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  for (genvar v = 0; v < vcr_pkg::NUM_VC; v++) begin : gen_vc
    vcr_pkg::flit_t                   mem_q [vcr_pkg::VC_DEPTH];
    logic [vcr_pkg::PTR_WIDTH-1:0]    wr_ptr_q;
    logic [vcr_pkg::PTR_WIDTH-1:0]    alloc_ptr_q;
    logic [vcr_pkg::PTR_WIDTH-1:0]    st_ptr_q;
    // written but not yet allocated
    logic [vcr_pkg::CREDIT_WIDTH-1:0] head_cnt_q;
    // written but not yet traversed
    logic [vcr_pkg::CREDIT_WIDTH-1:0] used_cnt_q;
    logic                             wr;
    logic                             ap;
    logic                             sp;

    assign wr = data_v_i && (int'(data_vc_i) == v);
    assign ap = alloc_pop_i && alloc_vc_oh_i[v];
    assign sp = st_pop_i && st_vc_oh_i[v];

    always_ff @(posedge clk_i) begin
      if (wr) begin
        mem_q[wr_ptr_q] <= data_i;
      end
    end

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        wr_ptr_q    <= '0;
        alloc_ptr_q <= '0;
        st_ptr_q    <= '0;
        head_cnt_q  <= '0;
        used_cnt_q  <= '0;
      end else begin
        if (wr) wr_ptr_q <= next_ptr(wr_ptr_q);
        if (ap) alloc_ptr_q <= next_ptr(alloc_ptr_q);
        if (sp) st_ptr_q <= next_ptr(st_ptr_q);
        if (wr && !ap) begin
          head_cnt_q <= head_cnt_q + 1'b1;
        end else if (ap && !wr) begin
          head_cnt_q <= head_cnt_q - 1'b1;
        end
        if (wr && !sp) begin
          used_cnt_q <= used_cnt_q + 1'b1;
        end else if (sp && !wr) begin
          used_cnt_q <= used_cnt_q - 1'b1;
        end
      end
    end

    assign head_v_o[v]   = (head_cnt_q != '0);
    assign head_dst_o[v] = mem_q[alloc_ptr_q].dst;
    assign st_head[v]    = mem_q[st_ptr_q];

    // upstream must hold a credit for every flit it sends
    a_no_overflow : assert property (@(posedge clk_i) disable iff (reset_i)
      wr |-> used_cnt_q != vcr_pkg::CREDIT_FULL);

    // allocation only ever picks a VC that shows a head
    a_pop_has_head : assert property (@(posedge clk_i) disable iff (reset_i)
      ap |-> head_cnt_q != '0);
  end

  // traversal read and credit return happen in the same cycle
  always_comb begin
    st_flit_o   = '0;
    credit_vc_o = '0;
    for (int v = 0; v < vcr_pkg::NUM_VC; v++) begin
      if (st_vc_oh_i[v]) begin
        st_flit_o   = st_head[v];
        credit_vc_o = v[vcr_pkg::VC_ID_WIDTH-1:0];
      end
    end
  end

  assign credit_v_o = st_pop_i;

endmodule

//--- verilog/sa_local.sv
// sa_local
// round-robin pick of one VC with a valid head inside one input

module sa_local (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [vcr_pkg::NUM_VC-1:0]           head_v_i,
  input  vcr_pkg::dir_e [vcr_pkg::NUM_VC-1:0]  head_dst_i,
  input  logic                                 update_i,
  output logic                                 req_v_o,
  output logic [vcr_pkg::NUM_VC-1:0]           req_vc_oh_o,
  output vcr_pkg::dir_e                        req_dst_o
);

  // last VC that won global allocation
  logic [vcr_pkg::VC_ID_WIDTH-1:0] last_q;
  logic [vcr_pkg::VC_ID_WIDTH-1:0] win_idx;

  // search starts one past the last winner
  always_comb begin
    int idx;
    req_v_o     = 1'b0;
    req_vc_oh_o = '0;
    req_dst_o   = vcr_pkg::DIR_NORTH;
    win_idx     = last_q;
    for (int i = 1; i <= vcr_pkg::NUM_VC; i++) begin
      idx = (int'(last_q) + i) % vcr_pkg::NUM_VC;
      if (!req_v_o && head_v_i[idx]) begin
        req_v_o          = 1'b1;
        req_vc_oh_o[idx] = 1'b1;
        req_dst_o        = head_dst_i[idx];
        win_idx          = idx[vcr_pkg::VC_ID_WIDTH-1:0];
      end
    end
  end

  // pointer moves only when this input was granted
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q <= '1;
    end else if (update_i) begin
      last_q <= win_idx;
    end
  end

  a_req_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_o |-> $onehot(req_vc_oh_o));

endmodule

//--- verilog/sa_global.sv
// sa_global
// round-robin grant of one output among the requesting inputs
// nothing is granted while the output has no free downstream VC

module sa_global (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic [vcr_pkg::NUM_PORTS-1:0] req_i,
  input  logic                          vc_avail_i,
  output logic                          grant_v_o,
  output logic [vcr_pkg::NUM_PORTS-1:0] grant_in_oh_o
);

  logic [$bits(vcr_pkg::dir_e)-1:0] last_q;
  logic [$bits(vcr_pkg::dir_e)-1:0] win_idx;

  always_comb begin
    int idx;
    grant_v_o     = 1'b0;
    grant_in_oh_o = '0;
    win_idx       = last_q;
    for (int i = 1; i <= vcr_pkg::NUM_PORTS; i++) begin
      idx = (int'(last_q) + i) % vcr_pkg::NUM_PORTS;
      if (vc_avail_i && !grant_v_o && req_i[idx]) begin
        grant_v_o          = 1'b1;
        grant_in_oh_o[idx] = 1'b1;
        win_idx            = idx[$bits(vcr_pkg::dir_e)-1:0];
      end
    end
  end

  // advance past the winner
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q <= '1;
    end else if (grant_v_o) begin
      last_q <= win_idx;
    end
  end

  a_grant_valid : assert property (@(posedge clk_i) disable iff (reset_i)
    grant_v_o |-> $onehot(grant_in_oh_o) && ((grant_in_oh_o & ~req_i) == '0));

endmodule

//--- verilog/vc_allocator.sv
// vc_allocator
// credit counters for the downstream VCs of one output
// picks the lowest-numbered VC that still has credit

module vc_allocator (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             consume_i,
  input  logic                             credit_v_i,
  input  logic [vcr_pkg::VC_ID_WIDTH-1:0]  credit_vc_i,
  output logic                             vc_avail_o,
  output logic [vcr_pkg::VC_ID_WIDTH-1:0]  vc_id_o
);

  logic [vcr_pkg::NUM_VC-1:0][vcr_pkg::CREDIT_WIDTH-1:0] cnt_q;

  // scan from the top so the lowest free VC wins
  always_comb begin
    vc_avail_o = 1'b0;
    vc_id_o    = '0;
    for (int v = vcr_pkg::NUM_VC - 1; v >= 0; v--) begin
      if (cnt_q[v] != '0) begin
        vc_avail_o = 1'b1;
        vc_id_o    = v[vcr_pkg::VC_ID_WIDTH-1:0];
      end
    end
  end

  for (genvar v = 0; v < vcr_pkg::NUM_VC; v++) begin : gen_cnt
    logic inc;
    logic dec;

    assign inc = credit_v_i && (int'(credit_vc_i) == v);
    assign dec = consume_i && (int'(vc_id_o) == v);

    // a consume and a return on one VC cancel out
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        cnt_q[v] <= vcr_pkg::CREDIT_FULL;
      end else if (inc && !dec) begin
        cnt_q[v] <= cnt_q[v] + 1'b1;
      end else if (dec && !inc) begin
        cnt_q[v] <= cnt_q[v] - 1'b1;
      end
    end

    // downstream never returns more than it was sent
    a_cnt_overflow : assert property (@(posedge clk_i) disable iff (reset_i)
      (inc && !dec) |-> cnt_q[v] != vcr_pkg::CREDIT_FULL);

    // global allocation only grants with a free VC
    a_cnt_underflow : assert property (@(posedge clk_i) disable iff (reset_i)
      (dec && !inc) |-> cnt_q[v] != '0);
  end

endmodule

//--- verilog/switch_traversal.sv
// switch_traversal
// register stage between allocation and traversal, then the crossbar
// pops each granted input and steers its flit to the granted output

module switch_traversal (
  input  logic                                                        clk_i,
  input  logic                                                        reset_i,
  input  logic [vcr_pkg::NUM_PORTS-1:0]                               grant_v_i,
  input  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::NUM_PORTS-1:0]       grant_in_oh_i,
  input  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::NUM_VC-1:0]          req_vc_oh_i,
  input  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::VC_ID_WIDTH-1:0]     vc_id_i,
  input  vcr_pkg::flit_t [vcr_pkg::NUM_PORTS-1:0]                     st_flit_i,
  output logic [vcr_pkg::NUM_PORTS-1:0]                               st_pop_o,
  output logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::NUM_VC-1:0]          st_vc_oh_o,
  output logic [vcr_pkg::NUM_PORTS-1:0]                               data_v_o,
  output logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::VC_ID_WIDTH-1:0]     data_vc_o,
  output vcr_pkg::flit_t [vcr_pkg::NUM_PORTS-1:0]                     data_o
);

  // ====================
  // stage register
  // ====================
  logic [vcr_pkg::NUM_PORTS-1:0]                           grant_v_q;
  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::NUM_PORTS-1:0]   grant_oh_q;
  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::NUM_VC-1:0]      vc_oh_q;
  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::VC_ID_WIDTH-1:0] vc_id_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      grant_v_q  <= '0;
      grant_oh_q <= '0;
    end else begin
      grant_v_q  <= grant_v_i;
      grant_oh_q <= grant_in_oh_i;
    end
  end

  always_ff @(posedge clk_i) begin
    vc_oh_q <= req_vc_oh_i;
    vc_id_q <= vc_id_i;
  end

  // ====================
  // crossbar
  // ====================
  for (genvar i = 0; i < vcr_pkg::NUM_PORTS; i++) begin : gen_in
    logic [vcr_pkg::NUM_PORTS-1:0] granted_by;
    logic [vcr_pkg::NUM_PORTS-1:0] granted_by_q;

    for (genvar o = 0; o < vcr_pkg::NUM_PORTS; o++) begin : gen_col
      assign granted_by[o]   = grant_in_oh_i[o][i];
      assign granted_by_q[o] = grant_oh_q[o][i];
    end

    assign st_pop_o[i]   = |granted_by_q;
    assign st_vc_oh_o[i] = st_pop_o[i] ? vc_oh_q[i] : '0;

    // one input carries one flit per cycle
    a_single_output : assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(granted_by));
  end

  always_comb begin
    data_o = '0;
    for (int o = 0; o < vcr_pkg::NUM_PORTS; o++) begin
      for (int i = 0; i < vcr_pkg::NUM_PORTS; i++) begin
        if (grant_oh_q[o][i]) begin
          data_o[o] = st_flit_i[i];
        end
      end
    end
  end

  assign data_v_o  = grant_v_q;
  assign data_vc_o = vc_id_q;

endmodule

//--- verilog/vc_router.sv
// vc_router
// four-port virtual-channel router with credit-based flow control
// switch allocation in one cycle, switch traversal in the next

module vc_router (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  input  logic [vcr_pkg::NUM_PORTS-1:0]                           data_v_i,
  input  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::VC_ID_WIDTH-1:0] data_vc_i,
  input  vcr_pkg::flit_t [vcr_pkg::NUM_PORTS-1:0]                 data_i,
  output logic [vcr_pkg::NUM_PORTS-1:0]                           credit_v_o,
  output logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::VC_ID_WIDTH-1:0] credit_vc_o,
  output logic [vcr_pkg::NUM_PORTS-1:0]                           data_v_o,
  output logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::VC_ID_WIDTH-1:0] data_vc_o,
  output vcr_pkg::flit_t [vcr_pkg::NUM_PORTS-1:0]                 data_o,
  input  logic [vcr_pkg::NUM_PORTS-1:0]                           credit_v_i,
  input  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::VC_ID_WIDTH-1:0] credit_vc_i
);

  // input space
  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::NUM_VC-1:0]          head_v;
  vcr_pkg::dir_e [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::NUM_VC-1:0] head_dst;
  logic [vcr_pkg::NUM_PORTS-1:0]                               req_v;
  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::NUM_VC-1:0]          req_vc_oh;
  vcr_pkg::dir_e [vcr_pkg::NUM_PORTS-1:0]                      req_dst;
  logic [vcr_pkg::NUM_PORTS-1:0]                               alloc_pop;
  logic [vcr_pkg::NUM_PORTS-1:0]                               st_pop;
  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::NUM_VC-1:0]          st_vc_oh;
  vcr_pkg::flit_t [vcr_pkg::NUM_PORTS-1:0]                     st_flit;
  // output space, indexed [output][input]
  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::NUM_PORTS-1:0]       req_per_out;
  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::NUM_PORTS-1:0]       grant_oh;
  logic [vcr_pkg::NUM_PORTS-1:0]                               grant_v;
  logic [vcr_pkg::NUM_PORTS-1:0]                               vc_avail;
  logic [vcr_pkg::NUM_PORTS-1:0][vcr_pkg::VC_ID_WIDTH-1:0]     vc_id;

  // ====================
  // input side
  // ====================
  for (genvar i = 0; i < vcr_pkg::NUM_PORTS; i++) begin : gen_in
    logic [vcr_pkg::NUM_PORTS-1:0] grant_per_in;

    vc_input_port input_port_inst (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .data_v_i     (data_v_i[i]),
      .data_vc_i    (data_vc_i[i]),
      .data_i       (data_i[i]),
      .credit_v_o   (credit_v_o[i]),
      .credit_vc_o  (credit_vc_o[i]),
      .head_v_o     (head_v[i]),
      .head_dst_o   (head_dst[i]),
      .alloc_pop_i  (alloc_pop[i]),
      .alloc_vc_oh_i(req_vc_oh[i]),
      .st_pop_i     (st_pop[i]),
      .st_vc_oh_i   (st_vc_oh[i]),
      .st_flit_o    (st_flit[i])
    );

    sa_local sa_local_inst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .head_v_i   (head_v[i]),
      .head_dst_i (head_dst[i]),
      .update_i   (alloc_pop[i]),
      .req_v_o    (req_v[i]),
      .req_vc_oh_o(req_vc_oh[i]),
      .req_dst_o  (req_dst[i])
    );

    // transpose between input and output space
    for (genvar o = 0; o < vcr_pkg::NUM_PORTS; o++) begin : gen_map
      assign req_per_out[o][i] = req_v[i] && (int'(req_dst[i]) == o);
      assign grant_per_in[o]   = grant_oh[o][i];
    end

    assign alloc_pop[i] = |grant_per_in;
  end

  // ====================
  // output side
  // ====================
  for (genvar o = 0; o < vcr_pkg::NUM_PORTS; o++) begin : gen_out
    sa_global sa_global_inst (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_i        (req_per_out[o]),
      .vc_avail_i   (vc_avail[o]),
      .grant_v_o    (grant_v[o]),
      .grant_in_oh_o(grant_oh[o])
    );

    vc_allocator vc_allocator_inst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .consume_i  (grant_v[o]),
      .credit_v_i (credit_v_i[o]),
      .credit_vc_i(credit_vc_i[o]),
      .vc_avail_o (vc_avail[o]),
      .vc_id_o    (vc_id[o])
    );
  end

  switch_traversal switch_traversal_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .grant_v_i    (grant_v),
    .grant_in_oh_i(grant_oh),
    .req_vc_oh_i  (req_vc_oh),
    .vc_id_i      (vc_id),
    .st_flit_i    (st_flit),
    .st_pop_o     (st_pop),
    .st_vc_oh_o   (st_vc_oh),
    .data_v_o     (data_v_o),
    .data_vc_o    (data_vc_o),
    .data_o       (data_o)
  );

endmodule

//--- include/tb_util.svh
// tb_util
// testbench helpers
// 32-bit LFSR step and the shared error report

`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// maximal-length taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic fb;
  fb = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], fb};
endfunction

// one error line with the simulation time
task automatic report_error(input string msg);
  $display("[ERROR] t=%0t %s", $time, msg);
endtask

`endif

//--- bench/vc_router_tb.sv
// vc_router_tb
// testbench for the four-port virtual-channel router
// upstream and downstream credit models, per-flow scoreboard and a watchdog

module vc_router_tb;

  `include "tb_util.svh"

  localparam int NP            = vcr_pkg::NUM_PORTS;
  localparam int NV            = vcr_pkg::NUM_VC;
  localparam int VCW           = vcr_pkg::VC_ID_WIDTH;
  localparam int PW            = vcr_pkg::PAYLOAD_WIDTH;
  localparam int CLK_PERIOD    = 10;
  localparam int DRIVE_DELAY   = 1;
  localparam int RESET_CYCLES  = 2;
  localparam int IDLE_CYCLES   = 3;
  localparam int RANDOM_CYCLES = 400;
  localparam int DRAIN_CYCLES  = 100;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES + 3 * DRAIN_CYCLES;
  // payload is {source port, source VC, tag}
  localparam int TAG_WIDTH     = PW - 2 - VCW;
  localparam logic [TAG_WIDTH-1:0] LONE_TAG = TAG_WIDTH'(13'h0c35);

  logic                               clk;
  logic                               reset;
  logic [NP-1:0]                      data_v_in;
  logic [NP-1:0][VCW-1:0]             data_vc_in;
  vcr_pkg::flit_t [NP-1:0]            data_in;
  logic [NP-1:0]                      credit_v_out;
  logic [NP-1:0][VCW-1:0]             credit_vc_out;
  logic [NP-1:0]                      data_v_out;
  logic [NP-1:0][VCW-1:0]             data_vc_out;
  vcr_pkg::flit_t [NP-1:0]            data_out;
  logic [NP-1:0]                      credit_v_in;
  logic [NP-1:0][VCW-1:0]             credit_vc_in;

  logic [31:0] lfsr_state = 32'd81896;
  int          cycle;
  logic        seen_input;
  int          sent_total;
  int          delivered_total;
  int          up_sent [NP][NV];
  int          up_returned [NP][NV];
  int          down_cnt [NP][NV];
  logic        ret_prev_v [NP];
  int          ret_prev_vc [NP];
  // one queue per input VC and output, oldest flit first
  logic [PW-1:0] sb_q [NP][NV][NP][$];
  // downstream credits waiting to go back, with their due cycle
  int          ret_vc_q [NP][$];
  int          ret_due_q [NP][$];

  vc_router vc_router_inst (
    .clk_i      (clk),
    .reset_i    (reset),
    .data_v_i   (data_v_in),
    .data_vc_i  (data_vc_in),
    .data_i     (data_in),
    .credit_v_o (credit_v_out),
    .credit_vc_o(credit_vc_out),
    .data_v_o   (data_v_out),
    .data_vc_o  (data_vc_out),
    .data_o     (data_out),
    .credit_v_i (credit_v_in),
    .credit_vc_i(credit_vc_in)
  );

  // ====================
  // helpers
  // ====================
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // VC the router should pick, -1 when no credit is held
  function automatic int lowest_credit_vc(input int o);
    for (int v = 0; v < NV; v++) begin
      if (down_cnt[o][v] > 0) begin
        return v;
      end
    end
    return -1;
  endfunction

  function automatic bit flows_clean();
    bit ok;
    ok = 1'b1;
    for (int i = 0; i < NP; i++) begin
      for (int v = 0; v < NV; v++) begin
        if (up_sent[i][v] != up_returned[i][v]) ok = 1'b0;
        for (int o = 0; o < NP; o++) begin
          if (sb_q[i][v][o].size() != 0) ok = 1'b0;
        end
      end
    end
    return ok;
  endfunction

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    report_error($sformatf("%s expected %0h got %0h", name, exp, got));
    abort_run();
  endtask

  task automatic complain(input string msg);
    report_error(msg);
    abort_run();
  endtask

  task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp == got) else mismatch(name, exp, got);
  endtask

  task automatic send_flit(input int p, input int vc, input vcr_pkg::dir_e dst,
                           input logic [TAG_WIDTH-1:0] tag);
    vcr_pkg::flit_t flit;
    flit.dst     = dst;
    flit.payload = {2'(p), VCW'(vc), tag};
    data_v_in[p]  = 1'b1;
    data_vc_in[p] = VCW'(vc);
    data_in[p]    = flit;
    sb_q[p][vc][int'(dst)].push_back(flit.payload);
    up_sent[p][vc]++;
    sent_total++;
    seen_input = 1'b1;
  endtask

  task automatic wait_drain();
    while (delivered_total != sent_total) begin
      @(posedge clk);
    end
  endtask

  // ====================
  // tests
  // ====================
  // idle router, exactly two cycles from input to output
  task automatic lone_flit_test();
    logic [PW-1:0] exp_payload;
    repeat (IDLE_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    exp_payload = {2'd2, VCW'(1), LONE_TAG};
    send_flit(2, 1, vcr_pkg::DIR_EAST, LONE_TAG);
    @(posedge clk);
    #DRIVE_DELAY;
    data_v_in = '0;
    @(negedge clk);
    expect_equal("data_v_o one cycle after the send", 0, data_v_out);
    @(negedge clk);
    expect_equal("data_v_o", 32'(1) << int'(vcr_pkg::DIR_EAST), data_v_out);
    expect_equal("data_o[1].payload", exp_payload, data_out[vcr_pkg::DIR_EAST].payload);
    expect_equal("credit_v_o", 32'(1) << 2, credit_v_out);
    expect_equal("credit_vc_o[2]", 1, credit_vc_out[2]);
  endtask

  // two inputs aim at the south output in one cycle
  task automatic contention_test();
    int got;
    int first_cyc;
    int first_src;
    int src;
    @(posedge clk);
    #DRIVE_DELAY;
    send_flit(0, 0, vcr_pkg::DIR_SOUTH, TAG_WIDTH'(13'h00aa));
    send_flit(3, 1, vcr_pkg::DIR_SOUTH, TAG_WIDTH'(13'h1155));
    @(posedge clk);
    #DRIVE_DELAY;
    data_v_in = '0;
    got = 0;
    first_cyc = 0;
    first_src = 0;
    while (got < 2) begin
      @(negedge clk);
      if (data_v_out[vcr_pkg::DIR_SOUTH]) begin
        src = int'(data_out[vcr_pkg::DIR_SOUTH].payload[PW-1 -: 2]);
        assert (src == 0 || src == 3) else complain("south output carried a flit of neither sender");
        if (got == 0) begin
          first_cyc = cycle;
          first_src = src;
        end else begin
          assert (cycle > first_cyc && src != first_src)
            else complain("the two competing flits did not leave in separate cycles");
        end
        got++;
      end
    end
  endtask

  task automatic random_traffic();
    int vc;
    logic [1:0] dst;
    logic [TAG_WIDTH-1:0] tag;
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      data_v_in = '0;
      for (int p = 0; p < NP; p++) begin
        if (take_bits(1) != 0) begin
          vc = int'(take_bits(VCW));
          // only send while holding a credit
          if (up_sent[p][vc] - up_returned[p][vc] < vcr_pkg::VC_DEPTH) begin
            dst = 2'(take_bits(2));
            tag = TAG_WIDTH'(take_bits(TAG_WIDTH));
            send_flit(p, vc, vcr_pkg::dir_e'(dst), tag);
          end
        end
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    data_v_in = '0;
  endtask

  // ====================
  // processes
  // ====================
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    cycle = 0;
    forever begin
      @(posedge clk);
      cycle++;
    end
  end

  // downstream routers hand credits back after a random delay
  initial begin
    credit_v_in  = '0;
    credit_vc_in = '0;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      credit_v_in = '0;
      for (int o = 0; o < NP; o++) begin
        if (!reset && ret_due_q[o].size() != 0 && ret_due_q[o][0] <= cycle) begin
          credit_v_in[o]  = 1'b1;
          credit_vc_in[o] = VCW'(ret_vc_q[o].pop_front());
          void'(ret_due_q[o].pop_front());
        end
      end
    end
  end

  // output monitor with the downstream and upstream credit models
  initial begin
    vcr_pkg::flit_t flit;
    int vc;
    int lo;
    bit found;
    delivered_total = 0;
    for (int o = 0; o < NP; o++) begin
      ret_prev_v[o]  = 1'b0;
      ret_prev_vc[o] = 0;
      for (int v = 0; v < NV; v++) begin
        down_cnt[o][v]    = vcr_pkg::VC_DEPTH;
        up_returned[o][v] = 0;
      end
    end
    forever begin
      @(negedge clk);
      if (!reset) begin
        for (int o = 0; o < NP; o++) begin
          if (data_v_out[o]) begin
            flit = data_out[o];
            vc   = int'(data_vc_out[o]);
            lo   = lowest_credit_vc(o);
            assert (down_cnt[o][vc] > 0)
              else complain($sformatf("output %0d sent a flit on VC %0d without a credit", o, vc));
            expect_equal($sformatf("data_vc_o[%0d]", o), lo, vc);
            expect_equal($sformatf("data_o[%0d].dst", o), o, flit.dst);
            found = 1'b0;
            for (int i = 0; i < NP; i++) begin
              for (int v = 0; v < NV; v++) begin
                if (!found && sb_q[i][v][o].size() != 0 && sb_q[i][v][o][0] == flit.payload) begin
                  void'(sb_q[i][v][o].pop_front());
                  found = 1'b1;
                end
              end
            end
            assert (found) else complain($sformatf(
              "output %0d delivered payload %0h, not the oldest flit of any flow", o, flit.payload));
            down_cnt[o][vc]--;
            delivered_total++;
            ret_vc_q[o].push_back(vc);
            ret_due_q[o].push_back(cycle + 1 + int'(take_bits(3)));
          end
          // the router counts a returned credit one cycle after the strobe
          if (ret_prev_v[o]) down_cnt[o][ret_prev_vc[o]]++;
          ret_prev_v[o]  = credit_v_in[o];
          ret_prev_vc[o] = int'(credit_vc_in[o]);
        end
        for (int p = 0; p < NP; p++) begin
          if (credit_v_out[p]) begin
            vc = int'(credit_vc_out[p]);
            assert (up_returned[p][vc] < up_sent[p][vc])
              else complain($sformatf("input %0d returned a credit on VC %0d it never used", p, vc));
            up_returned[p][vc]++;
          end
        end
      end
    end
  end

  // outputs stay quiet until the first flit is sent
  a_quiet_after_reset : assert property (@(posedge clk) disable iff (reset)
    !seen_input |-> (data_v_out == '0 && credit_v_out == '0))
    else complain("an output strobe rose before any flit was sent");

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    complain("watchdog expired before the traffic drained");
  end

  initial begin
    reset      = 1'b1;
    data_v_in  = '0;
    data_vc_in = '0;
    data_in    = '0;
    seen_input = 1'b0;
    sent_total = 0;
    for (int p = 0; p < NP; p++) begin
      for (int v = 0; v < NV; v++) begin
        up_sent[p][v] = 0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    lone_flit_test();
    wait_drain();
    contention_test();
    wait_drain();
    random_traffic();
    wait_drain();
    if (flows_clean()) begin
      $display("all tests passed");
      $finish;
    end else begin
      complain("flits or credits still outstanding after the traffic drained");
    end
  end

endmodule

//--- sim.f
+incdir+include
verilog/vcr_pkg.sv
verilog/vc_input_port.sv
verilog/sa_local.sv
verilog/sa_global.sv
verilog/vc_allocator.sv
verilog/switch_traversal.sv
verilog/vc_router.sv
bench/vc_router_tb.sv

//--- Makefile
# Verilator build and run for the virtual-channel router testbench

VERILATOR ?= verilator
TOP       ?= vc_router_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
